/* hdl/alu_pkg.sv */
package alu_pkg;

	// Iterations needed by multiply and divide
	// One step per operand bit
	localparam int STEPS = 32;

	// Operand and partial result word
	typedef logic [31:0] word_t;

	// Full result, wide enough for the product
	typedef logic [63:0] dword_t;

	// Shift amount taken from the low bits of b
	typedef logic [4:0] shamt_t;

	// Index of the current multiply or divide step
	typedef logic [$clog2(STEPS)-1:0] step_cnt_t;

	// Opcode encoding
	// Bit 0 selects subtract or right shift
	// Bit 1 selects negate or rotate
	// Shifts are 1 1 arith rot right
	typedef enum logic [4:0] {
		OP_NOT  = 5'b00001,
		OP_AND  = 5'b00010,
		OP_OR   = 5'b00011,
		OP_ADD  = 5'b00100,
		OP_SUB  = 5'b00101,
		OP_NEG  = 5'b00111,
		OP_MUL  = 5'b01000,
		OP_DIV  = 5'b01001,
		OP_SHL  = 5'b11000,
		OP_SHR  = 5'b11001,
		OP_ROL  = 5'b11010,
		OP_ROR  = 5'b11011,
		OP_SHLA = 5'b11100,
		OP_SHRA = 5'b11101
	} alu_op_e;

	// Controller states
	// EXEC registers the chosen result
	// RUN steps the iterative units
	typedef enum logic [1:0] {
		IDLE,
		EXEC,
		RUN,
		DONE
	} ctrl_state_e;

endpackage

/* hdl/alu_step_counter.sv */
`timescale 1ns/1ns

module alu_step_counter import alu_pkg::*; (
	input  logic clock,
	input  logic arst_n,
	input  logic load,
	input  logic step,
	output logic last
);

	step_cnt_t count_q;
	// Set once the final step has gone through
	logic      wrapped_q;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			count_q   <= '0;
			wrapped_q <= 1'b0;
		end else if (load) begin
			// Fresh operation starts at step zero
			count_q   <= '0;
			wrapped_q <= 1'b0;
		end else if (step) begin
			// Wraps back to zero after the last step
			count_q <= count_q + 1'b1;
			if (last)
				wrapped_q <= 1'b1;
		end
	end

	// High during the final step
	assign last = (count_q == step_cnt_t'(STEPS - 1));

	// Controller must leave RUN on the step flagged by last
	a_no_step_after_last: assert property (
		@(posedge clock) disable iff (!arst_n)
		step |-> !wrapped_q
	);

endmodule

/* hdl/alu_logic_unit.sv */
`timescale 1ns/1ns

module alu_logic_unit import alu_pkg::*; (
	input  logic    clock,
	input  logic    arst_n,
	input  logic    load,
	input  alu_op_e op,
	input  word_t   a,
	input  word_t   b,
	output dword_t  result
);

	alu_op_e op_q;
	word_t   a_q;
	word_t   b_q;

	// Adder path
	word_t   add_l;
	word_t   add_r;
	word_t   add_out;

	// Shifter path
	shamt_t  shamt;
	dword_t  rot_l;
	dword_t  rot_r;
	word_t   shift_out;

	word_t   low_word;

	// Opcode and operands captured as the request is accepted
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			op_q <= OP_NOT;
		else if (load)
			op_q <= op;
	end

	always_ff @(posedge clock) begin
		if (load) begin
			a_q <= a;
			b_q <= b;
		end
	end

	// Negate flag in bit 1 zeroes the left input
	assign add_l   = op_q[1] ? '0 : a_q;
	// Subtract flag in bit 0 gives two's complement of b
	assign add_r   = op_q[0] ? ~b_q : b_q;
	assign add_out = add_l + add_r + word_t'(op_q[0]);

	assign shamt = b_q[4:0];
	// Doubled word makes rotates fall out of plain shifts
	assign rot_l = {a_q, a_q} << shamt;
	assign rot_r = {a_q, a_q} >> shamt;

	always_comb begin
		if (op_q[1])
			// Rotate, direction from bit 0
			shift_out = op_q[0] ? rot_r[31:0] : rot_l[63:32];
		else if (op_q[0])
			// Arithmetic right fills with the sign of a
			shift_out = op_q[2] ? word_t'($signed(a_q) >>> shamt) : (a_q >> shamt);
		else
			// Arithmetic left is the same as logical left
			shift_out = a_q << shamt;
	end

	always_comb begin
		case (op_q)
			OP_NOT: low_word = ~a_q;
			OP_AND: low_word = a_q & b_q;
			OP_OR:  low_word = a_q | b_q;
			OP_ADD, OP_SUB, OP_NEG:
				low_word = add_out;
			OP_SHL, OP_SHR, OP_ROL, OP_ROR, OP_SHLA, OP_SHRA:
				low_word = shift_out;
			// Unknown or iterative opcodes give zero here
			default: low_word = '0;
		endcase
	end

	// Upper word stays zero for single-cycle ops
	assign result = dword_t'(low_word);

endmodule

/* hdl/alu_multiplier.sv */
`timescale 1ns/1ns

module alu_multiplier import alu_pkg::*; (
	input  logic   clock,
	input  logic   arst_n,
	input  logic   load,
	input  logic   step,
	input  word_t  a,
	input  word_t  b,
	output dword_t product
);

	// Multiplicand, fixed for the whole operation
	word_t              mcand_q;
	// Upper half accumulates, lower half holds the shifting multiplier
	dword_t             prod_q;
	// Upper half plus optional multiplicand, with carry
	logic [STEPS:0]     hi_sum;

	// Add when the current multiplier bit is set
	always_comb begin
		if (prod_q[0])
			hi_sum = {1'b0, prod_q[63:32]} + {1'b0, mcand_q};
		else
			hi_sum = {1'b0, prod_q[63:32]};
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			mcand_q <= '0;
			prod_q  <= '0;
		end else if (load) begin
			// Accumulator cleared, multiplier parked in the low half
			mcand_q <= a;
			prod_q  <= {32'b0, b};
		end else if (step) begin
			// Shift right one bit, the carry drops into bit 63
			// Used multiplier bit falls off the bottom
			prod_q <= {hi_sum, prod_q[STEPS-1:1]};
		end
	end

	// Valid once STEPS steps have passed
	assign product = prod_q;

endmodule

/* hdl/alu_divider.sv */
`timescale 1ns/1ns

module alu_divider import alu_pkg::*; (
	input  logic  clock,
	input  logic  arst_n,
	input  logic  load,
	input  logic  step,
	input  word_t a,
	input  word_t b,
	output word_t quotient,
	output word_t remainder
);

	// Divisor, fixed for the whole operation
	word_t            div_q;
	// Partial remainder
	word_t            rem_q;
	// Dividend bits shift out of the top, quotient bits shift in at the bottom
	word_t            quo_q;

	// Partial remainder with next dividend bit appended
	logic [STEPS:0]   shifted;
	// Trial subtraction, top bit is the borrow
	logic [STEPS+1:0] diff;
	logic             fits;

	assign shifted = {rem_q, quo_q[STEPS-1]};
	assign diff    = {1'b0, shifted} - {2'b0, div_q};
	// No borrow means the divisor fits
	assign fits    = !diff[STEPS+1];

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			div_q <= '0;
			rem_q <= '0;
			quo_q <= '0;
		end else if (load) begin
			div_q <= b;
			rem_q <= '0;
			quo_q <= a;
		end else if (step) begin
			// Restore by keeping the shifted value when it does not fit
			// A result below the divisor always fits in one word
			if (fits)
				rem_q <= diff[STEPS-1:0];
			else
				rem_q <= shifted[STEPS-1:0];
			// Record one quotient bit
			quo_q <= {quo_q[STEPS-2:0], fits};
		end
	end

	// Zero divisor always fits
	// so the quotient ends all ones and the remainder collects a
	assign quotient  = quo_q;
	assign remainder = rem_q;

endmodule

/* hdl/alu_ctrl.sv */
`timescale 1ns/1ns

module alu_ctrl import alu_pkg::*; (
	input  logic    clock,
	input  logic    arst_n,
	input  logic    req,
	input  alu_op_e op,
	input  logic    last,
	input  dword_t  logic_result,
	input  dword_t  product,
	input  word_t   quotient,
	input  word_t   remainder,
	output logic    load,
	output logic    step,
	output logic    ack,
	output dword_t  result
);

	ctrl_state_e state_q;
	// Own copy of the opcode for result selection
	alu_op_e     op_q;
	dword_t      sel_result;
	logic        iterative;

	// Multiply and divide go through RUN
	assign iterative = (op == OP_MUL) || (op == OP_DIV);

	// Accept a request straight from IDLE
	assign load = (state_q == IDLE) && req;
	// Iterative units advance every RUN cycle
	assign step = (state_q == RUN);

	always_comb begin
		case (op_q)
			OP_MUL:  sel_result = product;
			// Remainder in the upper word
			OP_DIV:  sel_result = {remainder, quotient};
			default: sel_result = logic_result;
		endcase
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= IDLE;
			op_q    <= OP_NOT;
			ack     <= 1'b0;
			result  <= '0;
		end else begin
			case (state_q)
				IDLE: begin
					if (req) begin
						op_q    <= op;
						state_q <= iterative ? RUN : EXEC;
					end
				end
				RUN: begin
					// Units are final after the step marked by last
					if (last)
						state_q <= EXEC;
				end
				EXEC: begin
					// Register the chosen result and acknowledge
					result  <= sel_result;
					ack     <= 1'b1;
					state_q <= DONE;
				end
				DONE: begin
					// Hold ack and result while req stays high
					if (!req) begin
						ack     <= 1'b0;
						state_q <= IDLE;
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// ack rises only in answer to a pending request
	a_ack_needs_req: assert property (
		@(posedge clock) disable iff (!arst_n)
		$rose(ack) |-> $past(req)
	);

	// Only multiply and divide ever step the iterative units
	a_step_in_run: assert property (
		@(posedge clock) disable iff (!arst_n)
		step |-> (op_q == OP_MUL) || (op_q == OP_DIV)
	);

endmodule

/* hdl/alu_top.sv */
`timescale 1ns/1ns

module alu_top import alu_pkg::*; (
	input  logic    clock,
	input  logic    arst_n,
	input  logic    req,
	input  alu_op_e op,
	input  word_t   a,
	input  word_t   b,
	output logic    ack,
	output dword_t  result
);

	// Controller strobes
	logic   load;
	logic   step;
	logic   last;

	// Datapath results back to the controller
	dword_t logic_result;
	dword_t product;
	word_t  quotient;
	word_t  remainder;

	alu_ctrl u_ctrl (
		.clock        (clock),
		.arst_n       (arst_n),
		.req          (req),
		.op           (op),
		.last         (last),
		.logic_result (logic_result),
		.product      (product),
		.quotient     (quotient),
		.remainder    (remainder),
		.load         (load),
		.step         (step),
		.ack          (ack),
		.result       (result)
	);

	// Shared step count for multiply and divide
	alu_step_counter u_step_counter (
		.clock  (clock),
		.arst_n (arst_n),
		.load   (load),
		.step   (step),
		.last   (last)
	);

	alu_logic_unit u_logic_unit (
		.clock  (clock),
		.arst_n (arst_n),
		.load   (load),
		.op     (op),
		.a      (a),
		.b      (b),
		.result (logic_result)
	);

	// Both iterative units run together, controller picks one
	alu_multiplier u_multiplier (
		.clock   (clock),
		.arst_n  (arst_n),
		.load    (load),
		.step    (step),
		.a       (a),
		.b       (b),
		.product (product)
	);

	alu_divider u_divider (
		.clock     (clock),
		.arst_n    (arst_n),
		.load      (load),
		.step      (step),
		.a         (a),
		.b         (b),
		.quotient  (quotient),
		.remainder (remainder)
	);

endmodule

/* sim/alu_tb.sv */
`timescale 1ns/1ns

module alu_tb import alu_pkg::*;;

	logic    clock;
	logic    arst_n;
	logic    req;
	alu_op_e op;
	word_t   a;
	word_t   b;
	logic    ack;
	dword_t  result;

	// Five words per test: opcode, a, b, expected upper, expected lower
	logic [31:0] test_mem [0:319];

	int errors;
	int tests_run;
	int cycles;
	int cycle_limit;
	int seed;

	alu_top DUT (
		.clock  (clock),
		.arst_n (arst_n),
		.req    (req),
		.op     (op),
		.a      (a),
		.b      (b),
		.ack    (ack),
		.result (result)
	);

	// 10 ns clock
	always #5 clock = ~clock;

	// Run guard, limit set once the test count is known
	always @(posedge clock) begin
		cycles = cycles + 1;
		if (cycles > cycle_limit) begin
			$display("Timeout: the DUT stopped answering after %0d cycles", cycles);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	task automatic check_value(input string what, input logic [63:0] got,
		input logic [63:0] expected);
		if (got !== expected) begin
			$display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, expected);
			errors = errors + 1;
		end
	endtask

	// One full handshake, optionally holding req high for extra cycles
	task automatic run_operation(input logic [4:0] op_v, input word_t a_v, input word_t b_v,
		input dword_t expected, input int hold);
		int     latency;
		int     errors_before;
		dword_t held;
		errors_before = errors;
		@(negedge clock);
		op  = alu_op_e'(op_v);
		a   = a_v;
		b   = b_v;
		req = 1'b1;
		// Count rising edges until ack shows up
		latency = 0;
		do begin
			@(posedge clock);
			latency = latency + 1;
			@(negedge clock);
		end while (!ack);
		// Iterative ops need STEPS extra cycles
		if (op_v == 5'b01000 || op_v == 5'b01001)
			check_value("latency", latency, 34);
		else
			check_value("latency", latency, 2);
		check_value("result", result, expected);
		held = result;
		// Back-pressure, nothing may move while req stays high
		repeat (hold) begin
			@(posedge clock);
			@(negedge clock);
			check_value("held ack", ack, 1);
			check_value("held result", result, held);
		end
		req = 1'b0;
		@(posedge clock);
		@(negedge clock);
		check_value("ack after req drop", ack, 0);
		tests_run = tests_run + 1;
		if (errors == errors_before)
			$display("test %0d op %02h ok", tests_run, op_v);
		else
			$display("test %0d op %02h FAILED", tests_run, op_v);
	endtask

	initial begin
		int          n_file;
		int          random_count;
		int          i;
		int          kind;
		logic [4:0]  rop;
		word_t       ra;
		word_t       rb;
		dword_t      rexp;
		clock        = 1'b0;
		arst_n       = 1'b0;
		req          = 1'b0;
		op           = OP_NOT;
		a            = '0;
		b            = '0;
		errors       = 0;
		tests_run    = 0;
		cycles       = 0;
		seed         = 13;
		random_count = 12;
		$readmemh("sim/alu_tests.txt", test_mem);
		// Unwritten entries stay unknown and mark the end
		n_file = 0;
		while (n_file < 64 && !$isunknown(test_mem[5 * n_file]))
			n_file = n_file + 1;
		if (n_file == 0) begin
			$display("No tests could be read from sim/alu_tests.txt");
			errors = errors + 1;
		end
		// Worst case is a held multiply, margin covers reset
		cycle_limit = (n_file + random_count) * 40 + 200;
		repeat (2) @(posedge clock);
		@(negedge clock);
		arst_n = 1'b1;
		check_value("ack after reset", ack, 0);
		check_value("result after reset", result, 0);
		// Every sixth test also exercises back-pressure
		for (i = 0; i < n_file; i++) begin
			run_operation(test_mem[5 * i][4:0], test_mem[5 * i + 1], test_mem[5 * i + 2],
				{test_mem[5 * i + 3], test_mem[5 * i + 4]}, (i % 6 == 2) ? 10 : 0);
		end
		// Random add, logic and multiply cases
		for (i = 0; i < random_count; i++) begin
			ra   = $random(seed);
			rb   = $random(seed);
			kind = $unsigned($random(seed)) % 5;
			case (kind)
				0: begin
					rop  = OP_ADD;
					rexp = {32'b0, ra + rb};
				end
				1: begin
					rop  = OP_AND;
					rexp = {32'b0, ra & rb};
				end
				2: begin
					rop  = OP_OR;
					rexp = {32'b0, ra | rb};
				end
				3: begin
					rop  = OP_NOT;
					rexp = {32'b0, ~ra};
				end
				default: begin
					rop  = OP_MUL;
					rexp = {32'b0, ra} * {32'b0, rb};
				end
			endcase
			run_operation(rop, ra, rb, rexp, 0);
		end
		$display("%0d tests run, %0d errors", tests_run, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* sim/alu_tests.txt */
// Columns: opcode a b expected_upper expected_lower, all hex
// Expected result for DIV is remainder in upper word, quotient in lower word
01 0F0F00FF 00000000 00000000 F0F0FF00
02 FF00FF00 0FF00FF0 00000000 0F000F00
03 FF00FF00 0FF00FF0 00000000 FFF0FFF0
04 12345678 11111111 00000000 23456789
04 FFFFFFFF 00000002 00000000 00000001
05 00000005 00000007 00000000 FFFFFFFE
05 80000000 00000001 00000000 7FFFFFFF
07 DEADBEEF 00000001 00000000 FFFFFFFF
18 80000001 00000000 00000000 80000001
18 80000001 00000001 00000000 00000002
18 80000001 0000001F 00000000 80000000
19 80000001 00000000 00000000 80000001
19 80000001 00000001 00000000 40000000
19 80000001 0000001F 00000000 00000001
1A 80000001 00000000 00000000 80000001
1A 80000001 00000001 00000000 00000003
1A 80000001 0000001F 00000000 C0000000
1B 80000001 00000000 00000000 80000001
1B 80000001 00000001 00000000 C0000000
1B 80000001 0000001F 00000000 00000003
1C 80000001 00000000 00000000 80000001
1C 80000001 00000001 00000000 00000002
1C 80000001 0000001F 00000000 80000000
1D 80000001 00000000 00000000 80000001
1D 80000001 00000001 00000000 C0000000
1D 80000001 0000001F 00000000 FFFFFFFF
08 FFFFFFFF FFFFFFFF FFFFFFFE 00000001
08 DEADBEEF 00010000 0000DEAD BEEF0000
09 00000064 00000007 00000002 0000000E
09 FFFFFFFF 00000010 0000000F 0FFFFFFF
09 12345678 00000000 12345678 FFFFFFFF
10 FFFFFFFF FFFFFFFF 00000000 00000000
1F 12345678 87654321 00000000 00000000

/* files.f */
hdl/alu_pkg.sv
hdl/alu_step_counter.sv
hdl/alu_logic_unit.sv
hdl/alu_multiplier.sv
hdl/alu_divider.sv
hdl/alu_ctrl.sv
hdl/alu_top.sv
sim/alu_tb.sv

/* Bender.yml */
package:
  name: alu

sources:
  - hdl/alu_pkg.sv
  - hdl/alu_step_counter.sv
  - hdl/alu_logic_unit.sv
  - hdl/alu_multiplier.sv
  - hdl/alu_divider.sv
  - hdl/alu_ctrl.sv
  - hdl/alu_top.sv
  - target: simulation
    files:
      - sim/alu_tb.sv
